// File: verification/fp_unit_stim.txt
// op rm a b clear result flags, in hex; op and rm use the fp_op_e and fp_rm_e codes.
// flags hold NV DZ OF UF NX in bits 4..0; clear 1 aborts the conversion midway.
0 0 3f800000 80000000 0 bf800000 00
1 0 00000001 00000000 0 80000001 00
2 0 bf800000 80000000 0 3f800000 00
9 0 ff800000 00000000 0 ff800000 00
8 0 80000000 00000000 0 00000008 00
8 0 00000001 00000000 0 00000020 00
8 0 7f800001 00000000 0 00000100 00
8 0 7fc00000 00000000 0 00000200 00
5 0 00000000 80000000 0 00000001 00
7 0 80000000 00000000 0 00000001 00
6 0 c0000000 bf800000 0 00000001 00
5 0 7fc00000 3f800000 0 00000000 00
5 0 7f800001 3f800000 0 00000000 10
6 0 7fc00000 3f800000 0 00000000 10
3 0 7fc00000 3f800000 0 3f800000 00
4 0 7f800001 bf800000 0 bf800000 10
3 0 7fc00000 7fa00000 0 7fc00000 10
3 0 00000000 80000000 0 80000000 00
4 0 00000000 80000000 0 00000000 00
a 0 7fffffff 00000000 0 4f000000 01
a 1 7fffffff 00000000 0 4effffff 01
a 2 7fffffff 00000000 0 4effffff 01
a 3 7fffffff 00000000 0 4f000000 01
a 4 7fffffff 00000000 0 4f000000 01
a 2 80000001 00000000 0 cf000000 01
a 3 80000001 00000000 0 ceffffff 01
a 0 00000000 00000000 0 00000000 00
b 4 00000001 00000000 0 3f800000 00
a 2 ffffffff 00000000 0 bf800000 00
a 3 80000000 00000000 0 cf000000 00
b 1 80000000 00000000 0 4f000000 00
b 0 00000001 00000000 1 00000000 00
a 0 00000001 00000000 0 3f800000 00

// File: project.f
+incdir+logic
logic/fp_pkg.sv
logic/fp_rnd_if.sv
logic/fp_ext.sv
logic/fp_cmp_max.sv
logic/fp_i2f.sv
logic/fp_rnd.sv
logic/fp_exe.sv
logic/fp_unit_top.sv
verification/fp_unit_checker.sv
verification/fp_unit_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TB_TOP     = fp_unit_tb
RTL_TOP    = fp_unit_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/fp_unit_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the FP unit. Replays the request table of the stim
// file and compares every result and flag set with the stored value.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_unit_tb import fp_pkg::*; ();

  localparam int clk_period = 100;
  localparam int max_lines  = 64;
  localparam int cols       = 7;    // op rm a b clear result flags.
  localparam int ready_wait = 40;

  logic        clk;
  logic        rst_n;
  logic        enable;
  fp_op_e      op;
  fp_rm_e      rm;
  logic [31:0] a;
  logic [31:0] b;
  logic        clear;
  logic [31:0] result;
  fp_flags_t   flags;
  logic        ready;
  logic        busy;

  logic [31:0] stim [max_lines*cols];
  int          n_lines;
  int          n_checks;
  int          n_mismatch;
  int          n_other;
  int          timeout_cycles;
  bit          loaded;

  always #(clk_period/2) clk = ~clk;

  fp_unit_top i_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .enable_i (enable),
    .op_i     (op),
    .rm_i     (rm),
    .a_i      (a),
    .b_i      (b),
    .clear_i  (clear),
    .result_o (result),
    .flags_o  (flags),
    .ready_o  (ready),
    .busy_o   (busy)
  );

  bind fp_unit_top fp_unit_checker i_checker (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enable_i (enable_i),
    .op_i     (op_i),
    .clear_i  (clear_i),
    .ready_i  (ready_o),
    .busy_i   (busy_o)
  );

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (busy && cnt < ready_wait) begin
      step_cycle();
      cnt++;
    end
    if (busy) begin
      n_other++;
      $display("ERROR at %0t: busy_o stayed high for %0d cycles", $time, ready_wait);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One request from the table.
  task automatic run_line(input int idx);
    int base;
    int cnt;
    bit is_cvt;
    base = idx * cols;
    wait_idle();
    enable = 1'b1;
    op     = fp_op_e'(stim[base][3:0]);
    rm     = fp_rm_e'(stim[base+1][2:0]);
    a      = stim[base+2];
    b      = stim[base+3];
    is_cvt = (op == FCVT_S_W) || (op == FCVT_S_WU);
    step_cycle();                                   // Accepting edge.
    enable = 1'b0;
    cnt    = 0;
    if (!is_cvt) begin
      check_val(ready, 1'b1, $sformatf("line %0d ready after one cycle", idx));
    end else if (stim[base+4][0]) begin
      check_val(busy, 1'b1, $sformatf("line %0d busy after accept", idx));
      repeat (3) step_cycle();
      clear = 1'b1;
      step_cycle();
      check_val(busy, 1'b0, $sformatf("line %0d busy after clear", idx));
      // Clear stays high past the point where the conversion would end.
      while (!ready && cnt < ready_wait) begin
        step_cycle();
        cnt++;
      end
      clear = 1'b0;
      check_val(ready, 1'b0, $sformatf("line %0d ready after clear", idx));
    end else begin
      while (!ready && cnt < ready_wait) begin
        check_val(busy, 1'b1, $sformatf("line %0d busy while converting", idx));
        step_cycle();
        cnt++;
      end
      if (!ready) begin
        n_other++;
        $display("ERROR at %0t: line %0d got no ready_o within %0d cycles",
                 $time, idx, ready_wait);
      end else begin
        check_val(busy, 1'b0, $sformatf("line %0d busy with ready", idx));
      end
    end
    check_val(result, stim[base+5], $sformatf("line %0d result", idx));
    check_val({27'd0, flags}, stim[base+6], $sformatf("line %0d flags", idx));
    step_cycle();
    check_val(ready, 1'b0, $sformatf("line %0d ready pulse width", idx));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence.
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    enable     = 1'b0;
    op         = FSGNJ;
    rm         = RNE;
    a          = '0;
    b          = '0;
    clear      = 1'b0;
    n_checks   = 0;
    n_mismatch = 0;
    n_other    = 0;
    n_lines    = 0;
    for (int i = 0; i < max_lines*cols; i++) begin
      stim[i] = 32'hffff_ffff;                      // End marker.
    end
    $readmemh("verification/fp_unit_stim.txt", stim);
    while (n_lines < max_lines && stim[n_lines*cols] != 32'hffff_ffff) n_lines++;
    timeout_cycles = n_lines * 40 + 8 + 4;
    loaded = 1'b1;
    if (n_lines == 0) begin
      n_other++;
      $display("ERROR: the stim file holds no requests");
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_cycle();
    check_val(result, '0, "result after reset");
    check_val({27'd0, flags}, '0, "flags after reset");
    check_val({ready, busy}, 2'b00, "ready and busy after reset");
    for (int i = 0; i < n_lines; i++) begin
      run_line(i);
    end
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    wait (loaded);
    #(timeout_cycles * clk_period);
    $display("ERROR: the run timed out after %0d cycles", timeout_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verification/fp_unit_checker.sv
//////////////////////////////////////////////////////////////////////
// Assertions on the ready, busy and clear behavior of the FP unit.
// Bound to the top level from the testbench.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fp_unit_checker import fp_pkg::*; (
  input logic   clk_i,
  input logic   rst_n_i,
  input logic   enable_i,
  input fp_op_e op_i,
  input logic   clear_i,
  input logic   ready_i,
  input logic   busy_i
);

  logic single_req;

  // Accepted request that completes in one cycle.
  assign single_req = enable_i & ~busy_i & ~clear_i & (op_i != FCVT_S_W) & (op_i != FCVT_S_WU);

  ready_busy_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ready_i && busy_i))
    else $error("ready and busy are high together");

  ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ready_i |=> !ready_i)
    else $error("ready is longer than one cycle");

  single_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    single_req |=> ready_i)
    else $error("single-cycle request without ready on the next edge");

  clear_kills_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clear_i |=> !ready_i)
    else $error("ready after clear");

endmodule

// File: logic/fp_unit_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the single-precision FP unit with plain ports.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_unit_top import fp_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             enable_i,
  input  fp_op_e           op_i,
  input  fp_rm_e           rm_i,
  input  logic [`FP_W-1:0] a_i,
  input  logic [`FP_W-1:0] b_i,
  input  logic             clear_i,
  output logic [`FP_W-1:0] result_o,
  output fp_flags_t        flags_o,
  output logic             ready_o,
  output logic             busy_o
);

  logic [`FP_W-1:0]       op_a;
  logic [`FP_W-1:0]       op_b;
  logic                   sign_a;
  logic                   sign_b;
  logic [`FP_CLASS_W-1:0] class_a;
  logic [`FP_CLASS_W-1:0] class_b;
  logic [`FP_W-1:0]       cmp_result;
  fp_flags_t              cmp_flags;
  logic [`FP_W-1:0]       rnd_result;
  fp_flags_t              rnd_flags;
  logic                   i2f_busy;
  logic                   i2f_start;
  logic                   i2f_signed;
  fp_rm_e                 i2f_rm;

  fp_rnd_if rnd_if ();

  fp_exe i_exe (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear_i),
    .enable_i     (enable_i),
    .op_i         (op_i),
    .rm_i         (rm_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .class_a_i    (class_a),
    .sign_a_i     (sign_a),
    .sign_b_i     (sign_b),
    .cmp_result_i (cmp_result),
    .cmp_flags_i  (cmp_flags),
    .rnd_result_i (rnd_result),
    .rnd_flags_i  (rnd_flags),
    .rnd          (rnd_if.mon),
    .i2f_busy_i   (i2f_busy),
    .i2f_start_o  (i2f_start),
    .i2f_signed_o (i2f_signed),
    .i2f_rm_o     (i2f_rm),
    .result_o     (result_o),
    .flags_o      (flags_o),
    .ready_o      (ready_o),
    .busy_o       (busy_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Operand unpack, only sign and class are needed downstream.
  fp_ext i_ext_a (
    .data_i  (op_a),
    .sign_o  (sign_a),
    .exp_o   (),
    .man_o   (),
    .class_o (class_a)
  );

  fp_ext i_ext_b (
    .data_i  (op_b),
    .sign_o  (sign_b),
    .exp_o   (),
    .man_o   (),
    .class_o (class_b)
  );

  fp_cmp_max i_cmp_max (
    .a_i          (op_a),
    .b_i          (op_b),
    .class_a_i    (class_a),
    .class_b_i    (class_b),
    .op_i         (op_i),
    .cmp_result_o (cmp_result),
    .cmp_flags_o  (cmp_flags)
  );

  //////////////////////////////////////////////////////////////////////
  // Integer conversion path.
  fp_i2f i_i2f (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .start_i     (i2f_start),
    .int_i       (op_a),
    .is_signed_i (i2f_signed),
    .rm_i        (i2f_rm),
    .busy_o      (i2f_busy),
    .rnd         (rnd_if.src)
  );

  fp_rnd i_rnd (
    .rnd      (rnd_if.snk),
    .result_o (rnd_result),
    .flags_o  (rnd_flags)
  );

endmodule

// File: logic/fp_exe.sv
//////////////////////////////////////////////////////////////////////
// Dispatcher of the FP unit. Accepts a request, routes the operands,
// selects one result and flag set, and registers them with ready.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_exe import fp_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  logic                   enable_i,
  input  fp_op_e                 op_i,
  input  fp_rm_e                 rm_i,
  input  logic [`FP_W-1:0]       a_i,
  input  logic [`FP_W-1:0]       b_i,
  // Unit side.
  output logic [`FP_W-1:0]       op_a_o,
  output logic [`FP_W-1:0]       op_b_o,
  input  logic [`FP_CLASS_W-1:0] class_a_i,
  input  logic                   sign_a_i,
  input  logic                   sign_b_i,
  input  logic [`FP_W-1:0]       cmp_result_i,
  input  fp_flags_t              cmp_flags_i,
  input  logic [`FP_W-1:0]       rnd_result_i,
  input  fp_flags_t              rnd_flags_i,
  fp_rnd_if.mon                  rnd,
  input  logic                   i2f_busy_i,
  output logic                   i2f_start_o,
  output logic                   i2f_signed_o,
  output fp_rm_e                 i2f_rm_o,
  // Request side.
  output logic [`FP_W-1:0]       result_o,
  output fp_flags_t              flags_o,
  output logic                   ready_o,
  output logic                   busy_o
);

  logic             accept;
  logic             is_cvt;
  logic [`FP_W-1:0] single_res;
  fp_flags_t        single_flags;

  assign op_a_o = enable_i ? a_i : '0;   // Idle operands held at zero.
  assign op_b_o = enable_i ? b_i : '0;

  assign accept = enable_i & ~i2f_busy_i & ~clear_i;
  assign is_cvt = (op_i == FCVT_S_W) || (op_i == FCVT_S_WU);

  assign i2f_start_o  = accept & is_cvt;
  assign i2f_signed_o = (op_i == FCVT_S_W);
  assign i2f_rm_o     = rm_i;
  assign busy_o       = i2f_busy_i;

  //////////////////////////////////////////////////////////////////////
  // Single-cycle results.
  always_comb begin
    single_res   = '0;
    single_flags = '0;
    case (op_i)
      FSGNJ:  single_res = {sign_b_i, op_a_o[`FP_W-2:0]};
      FSGNJN: single_res = {~sign_b_i, op_a_o[`FP_W-2:0]};
      FSGNJX: single_res = {sign_a_i ^ sign_b_i, op_a_o[`FP_W-2:0]};
      FMIN, FMAX, FEQ, FLT, FLE: begin
        single_res   = cmp_result_i;
        single_flags = cmp_flags_i;
      end
      FCLASS: single_res = {{(`FP_W-`FP_CLASS_W){1'b0}}, class_a_i};
      FMV:    single_res = op_a_o;
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      flags_o  <= '0;
      ready_o  <= 1'b0;
    end else if (clear_i) begin
      result_o <= '0;   // Aborted work leaves nothing behind.
      flags_o  <= '0;
      ready_o  <= 1'b0;
    end else if (rnd.valid) begin
      result_o <= rnd_result_i;
      flags_o  <= rnd_flags_i;
      ready_o  <= 1'b1;
    end else if (accept && !is_cvt) begin
      result_o <= single_res;
      flags_o  <= single_flags;
      ready_o  <= 1'b1;
    end else begin
      ready_o <= 1'b0;
    end
  end

endmodule

// File: logic/fp_rnd.sv
//////////////////////////////////////////////////////////////////////
// Rounds a normalized significand and packs the binary32 result.
// Combinational; the exponent range of 32-bit integers cannot overflow.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_rnd import fp_pkg::*; (
  fp_rnd_if.snk            rnd,
  output logic [`FP_W-1:0] result_o,
  output fp_flags_t        flags_o
);

  logic                  inexact;
  logic                  round_up;
  logic [`FP_MAN_W+1:0]  sum;
  logic                  carry;
  logic [`FP_EXP_W-1:0]  exp_r;
  logic [`FP_MAN_W-1:0]  frac_r;

  assign inexact = rnd.guard | rnd.round | rnd.sticky;

  always_comb begin
    case (rnd.rm)
      RNE:     round_up = rnd.guard & (rnd.round | rnd.sticky | rnd.sig[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = inexact & rnd.sign;
      RUP:     round_up = inexact & ~rnd.sign;
      RMM:     round_up = rnd.guard;  // Ties away from zero.
      default: round_up = 1'b0;
    endcase
  end

  assign sum   = {1'b0, rnd.sig} + {{(`FP_MAN_W+1){1'b0}}, round_up};
  assign carry = sum[`FP_MAN_W+1];

  // A carry out leaves 1.000..., so the fraction comes from one bit higher.
  assign exp_r  = rnd.exp + {{(`FP_EXP_W-1){1'b0}}, carry};
  assign frac_r = carry ? sum[`FP_MAN_W:1] : sum[`FP_MAN_W-1:0];

  assign result_o = {rnd.sign, exp_r, frac_r};

  always_comb begin
    flags_o    = '0;
    flags_o.nx = inexact;
  end

endmodule

// File: logic/fp_i2f.sv
//////////////////////////////////////////////////////////////////////
// Integer to binary32 normalizer, one left shift per clock cycle.
// The unrounded value is handed to the rounder in the DONE state.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_i2f import fp_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic [`FP_W-1:0] int_i,
  input  logic             is_signed_i,
  input  fp_rm_e           rm_i,
  output logic             busy_o,
  fp_rnd_if.src            rnd
);

  // Exponent of a value whose top set bit is bit 31.
  localparam logic [`FP_EXP_W-1:0] exp_top = `FP_EXP_W'(`FP_BIAS + `FP_W - 1);
  localparam int unsigned grd_bit = `FP_W - `FP_MAN_W - 2;

  i2f_state_e           state_q;
  logic [`FP_W-1:0]     mag_q;
  logic [`FP_W-1:0]     mag_in;
  logic [`FP_EXP_W-1:0] exp_q;
  logic                 sign_q;
  logic                 neg_in;
  logic                 zero_in;
  fp_rm_e               rm_q;

  assign neg_in  = is_signed_i & int_i[`FP_W-1];
  assign mag_in  = neg_in ? -int_i : int_i;
  assign zero_in = (mag_in == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (start_i) state_q <= (zero_in | mag_in[`FP_W-1]) ? DONE : SHIFT;
        SHIFT:   if (mag_q[`FP_W-2]) state_q <= DONE;  // Top bit set after this shift.
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      mag_q  <= mag_in;
      sign_q <= neg_in;
      rm_q   <= rm_i;
      exp_q  <= zero_in ? '0 : exp_top;
    end else if (state_q == SHIFT) begin
      mag_q <= mag_q << 1;
      exp_q <= exp_q - 1'b1;
    end
  end

  assign busy_o = (state_q != IDLE);

  assign rnd.sign   = sign_q;
  assign rnd.exp    = exp_q;
  assign rnd.sig    = mag_q[`FP_W-1 -: `FP_MAN_W+1];
  assign rnd.guard  = mag_q[grd_bit];
  assign rnd.round  = mag_q[grd_bit-1];
  assign rnd.sticky = |mag_q[grd_bit-2:0];
  assign rnd.rm     = rm_q;
  assign rnd.valid  = (state_q == DONE);

endmodule

// File: logic/fp_cmp_max.sv
//////////////////////////////////////////////////////////////////////
// Comparisons (FEQ, FLT, FLE) and FMIN/FMAX, combinational.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_cmp_max import fp_pkg::*; (
  input  logic [`FP_W-1:0]       a_i,
  input  logic [`FP_W-1:0]       b_i,
  input  logic [`FP_CLASS_W-1:0] class_a_i,
  input  logic [`FP_CLASS_W-1:0] class_b_i,
  input  fp_op_e                 op_i,
  output logic [`FP_W-1:0]       cmp_result_o,
  output fp_flags_t              cmp_flags_o
);

  logic nan_a;
  logic nan_b;
  logic snan_any;
  logic both_zero;
  logic sign_a;
  logic sign_b;
  logic mag_lt;
  logic mag_gt;
  logic eq;
  logic lt;
  logic lt_tot;

  assign nan_a     = class_a_i[8] | class_a_i[9];
  assign nan_b     = class_b_i[8] | class_b_i[9];
  assign snan_any  = class_a_i[8] | class_b_i[8];
  assign both_zero = (class_a_i[3] | class_a_i[4]) & (class_b_i[3] | class_b_i[4]);

  assign sign_a = a_i[`FP_W-1];
  assign sign_b = b_i[`FP_W-1];
  assign mag_lt = a_i[`FP_W-2:0] < b_i[`FP_W-2:0];
  assign mag_gt = a_i[`FP_W-2:0] > b_i[`FP_W-2:0];

  assign eq = both_zero | (a_i == b_i);

  always_comb begin
    if (both_zero) lt = 1'b0;
    else if (sign_a != sign_b) lt = sign_a;
    else lt = sign_a ? mag_gt : mag_lt;   // Negative values order reversed.
  end

  // Min and max also place -0 below +0.
  assign lt_tot = lt | (both_zero & sign_a & ~sign_b);

  always_comb begin
    cmp_result_o = '0;
    cmp_flags_o  = '0;
    case (op_i)
      FEQ: begin
        cmp_result_o[0] = ~nan_a & ~nan_b & eq;
        cmp_flags_o.nv  = snan_any;
      end
      FLT: begin
        cmp_result_o[0] = ~nan_a & ~nan_b & lt;
        cmp_flags_o.nv  = nan_a | nan_b;
      end
      FLE: begin
        cmp_result_o[0] = ~nan_a & ~nan_b & (lt | eq);
        cmp_flags_o.nv  = nan_a | nan_b;
      end
      FMIN, FMAX: begin
        cmp_flags_o.nv = snan_any;
        if (nan_a & nan_b) cmp_result_o = `FP_QNAN;
        else if (nan_a) cmp_result_o = b_i;
        else if (nan_b) cmp_result_o = a_i;
        else if ((op_i == FMIN) == lt_tot) cmp_result_o = a_i;
        else cmp_result_o = b_i;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: logic/fp_ext.sv
//////////////////////////////////////////////////////////////////////
// Splits one binary32 operand into its fields and classifies it.
// One instance per source operand.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

module fp_ext (
  input  logic [`FP_W-1:0]       data_i,
  output logic                   sign_o,
  output logic [`FP_EXP_W-1:0]   exp_o,
  output logic [`FP_MAN_W-1:0]   man_o,
  output logic [`FP_CLASS_W-1:0] class_o
);

  logic exp_max;
  logic exp_zero;
  logic man_zero;
  logic is_inf;
  logic is_nan;
  logic is_norm;
  logic is_sub;
  logic is_zero;

  assign sign_o = data_i[`FP_W-1];
  assign exp_o  = data_i[`FP_W-2 -: `FP_EXP_W];
  assign man_o  = data_i[`FP_MAN_W-1:0];

  assign exp_max  = &exp_o;
  assign exp_zero = ~|exp_o;
  assign man_zero = ~|man_o;

  assign is_inf  = exp_max & man_zero;
  assign is_nan  = exp_max & ~man_zero;
  assign is_norm = ~exp_max & ~exp_zero;
  assign is_sub  = exp_zero & ~man_zero;
  assign is_zero = exp_zero & man_zero;

  // Negative classes occupy the low half, positive ones mirror them.
  assign class_o[0] = sign_o & is_inf;
  assign class_o[1] = sign_o & is_norm;
  assign class_o[2] = sign_o & is_sub;
  assign class_o[3] = sign_o & is_zero;
  assign class_o[4] = ~sign_o & is_zero;
  assign class_o[5] = ~sign_o & is_sub;
  assign class_o[6] = ~sign_o & is_norm;
  assign class_o[7] = ~sign_o & is_inf;
  assign class_o[8] = is_nan & ~man_o[`FP_MAN_W-1];  // Signalling.
  assign class_o[9] = is_nan & man_o[`FP_MAN_W-1];   // Quiet.

endmodule

// File: logic/fp_rnd_if.sv
//////////////////////////////////////////////////////////////////////
// Unrounded value from the integer normalizer to the rounder.
// valid pulses for one cycle; the rounder never stalls the source.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fp_cfg.svh"

interface fp_rnd_if import fp_pkg::*; ();

  logic                 sign;
  logic [`FP_EXP_W-1:0] exp;     // Biased exponent.
  logic [`FP_MAN_W:0]   sig;     // Significand with the hidden bit.
  logic                 guard;
  logic                 round;
  logic                 sticky;
  fp_rm_e               rm;
  logic                 valid;

  modport src (output sign, exp, sig, guard, round, sticky, rm, valid);

  modport snk (input sign, exp, sig, guard, round, sticky, rm, valid);

  modport mon (input valid);

endinterface

// File: logic/fp_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the floating-point execution unit.
//////////////////////////////////////////////////////////////////////

package fp_pkg;

  // Operation codes, in the order used by the stimulus file.
  typedef enum logic [3:0] {
    FSGNJ     = 4'd0,
    FSGNJN    = 4'd1,
    FSGNJX    = 4'd2,
    FMIN      = 4'd3,
    FMAX      = 4'd4,
    FEQ       = 4'd5,
    FLT       = 4'd6,
    FLE       = 4'd7,
    FCLASS    = 4'd8,
    FMV       = 4'd9,
    FCVT_S_W  = 4'd10,
    FCVT_S_WU = 4'd11
  } fp_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } fp_rm_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SHIFT = 2'd1,
    DONE  = 2'd2
  } i2f_state_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage

// File: logic/fp_cfg.svh
//////////////////////////////////////////////////////////////////////
// Binary32 format constants for the floating-point execution unit.
// Included by every RTL file that sizes operands or fields.
//////////////////////////////////////////////////////////////////////

`ifndef FP_CFG_SVH
`define FP_CFG_SVH

// Operand and field widths.
`define FP_W        32
`define FP_EXP_W    8
`define FP_MAN_W    23

`define FP_BIAS     127

// Canonical quiet NaN returned by min and max when both inputs are NaN.
`define FP_QNAN     32'h7fc0_0000

`define FP_CLASS_W  10     // One-hot class, negative infinity in bit 0.

`endif
